// ==== keypad_stats_top.f ====
+incdir+verification
common/keypad_pkg.sv
ps2_rx/ps2_frame_receiver.sv
ps2_rx/ps2_make_filter.sv
rtl/key_history.sv
rtl/digit_tally.sv
rtl/keypad_stats_top.sv
verification/keypad_stats_tb.sv

// ==== Bender.yml ====
package:
  name: keypad_stats

sources:
  - files:
      - common/keypad_pkg.sv
      - ps2_rx/ps2_frame_receiver.sv
      - ps2_rx/ps2_make_filter.sv
      - rtl/key_history.sv
      - rtl/digit_tally.sv
      - rtl/keypad_stats_top.sv
  - target: simulation
    include_dirs:
      - verification
    files:
      - verification/keypad_stats_tb.sv

// ==== verification/ps2_device_model.svh ====
// PS/2 keyboard model
// Drives 11-bit frames onto ps2_clock and ps2_data, with good or flipped parity.
// Included inside the testbench module, uses its clock and PS/2 lines.

`ifndef PS2_DEVICE_MODEL_SVH
`define PS2_DEVICE_MODEL_SVH

localparam int PS2_HALF_PERIOD = 20;  // System cycles per PS/2 clock phase

task automatic wait_ps2_half_period();
	repeat (PS2_HALF_PERIOD) @(negedge CLOCK_50_I);
endtask

// Start, data LSB first, parity, stop
task automatic drive_ps2_frame(input keypad_pkg::scan_code_t code, input logic flip_parity);
	logic [10:0] frame;
	frame = {1'b1, (~^code) ^ flip_parity, code, 1'b0};  // Odd parity unless flipped
	for (int i = 0; i < 11; i++) begin
		ps2_data = frame[i];  // Changes while the clock is high
		wait_ps2_half_period();
		ps2_clock = 1'b0;
		wait_ps2_half_period();
		ps2_clock = 1'b1;
	end
	ps2_data = 1'b1;
	wait_ps2_half_period();  // Idle gap after the stop bit
endtask

task automatic send_byte(input keypad_pkg::scan_code_t code);
	drive_ps2_frame(code, 1'b0);
endtask

task automatic send_byte_bad_parity(input keypad_pkg::scan_code_t code);
	drive_ps2_frame(code, 1'b1);
endtask

`endif

// ==== verification/keypad_stats_tb.sv ====
// Keypad statistics testbench
// Plays a table of key events into the DUT over PS/2 and checks the reported
// digit statistics and frame error pulses against a reference model.

`timescale 1ns/1ps

module keypad_stats_tb;

	typedef enum logic [2:0] {
		EV_NONE,
		EV_PRESS,
		EV_PRESS_RELEASE,
		EV_EXTENDED,
		EV_BAD_PARITY
	} event_kind_t;

	typedef struct packed {
		event_kind_t            kind;
		keypad_pkg::scan_code_t code;
		logic [4:0]             repeats;  // Times the event is applied
	} key_event_t;

	localparam int NUM_TESTS  = 8;
	localparam int MAX_EVENTS = 3;
	localparam int TIMEOUT    = 2000;  // System cycles

	logic CLOCK_50_I;
	logic resetn;
	logic ps2_clock;
	logic ps2_data;
	logic frame_error;
	logic error_seen;
	keypad_pkg::key_stats_t key_stats;

	keypad_pkg::digit_t model_history [keypad_pkg::HISTORY_DEPTH];
	keypad_pkg::scan_code_t digit_codes [10] = '{8'h45, 8'h16, 8'h1E, 8'h26, 8'h25,
		8'h2E, 8'h36, 8'h3D, 8'h3E, 8'h46};
	integer seed = 32'hc6a264c9;

	string test_names [NUM_TESTS] = '{"single_press_release", "extended_key",
		"mixed_digits", "tie_higher_digit", "history_wrap", "non_digit_flush",
		"all_non_digit", "bad_parity"};

	key_event_t test_events [NUM_TESTS][MAX_EVENTS] = '{
		'{'{EV_PRESS_RELEASE, 8'h2E, 5'd1}, '{EV_NONE, 8'h00, 5'd0}, '{EV_NONE, 8'h00, 5'd0}},
		'{'{EV_EXTENDED, 8'h75, 5'd14}, '{EV_NONE, 8'h00, 5'd0}, '{EV_NONE, 8'h00, 5'd0}},
		'{'{EV_PRESS, 8'h16, 5'd2}, '{EV_PRESS, 8'h26, 5'd3}, '{EV_PRESS_RELEASE, 8'h16, 5'd1}},
		'{'{EV_PRESS, 8'h45, 5'd4}, '{EV_PRESS, 8'h46, 5'd4}, '{EV_NONE, 8'h00, 5'd0}},
		'{'{EV_PRESS, 8'h3E, 5'd3}, '{EV_PRESS, 8'h3D, 5'd15}, '{EV_NONE, 8'h00, 5'd0}},
		'{'{EV_PRESS, 8'h1C, 5'd10}, '{EV_NONE, 8'h00, 5'd0}, '{EV_NONE, 8'h00, 5'd0}},
		'{'{EV_PRESS_RELEASE, 8'h1C, 5'd5}, '{EV_NONE, 8'h00, 5'd0}, '{EV_NONE, 8'h00, 5'd0}},
		'{'{EV_PRESS, 8'h36, 5'd1}, '{EV_BAD_PARITY, 8'h36, 5'd1}, '{EV_NONE, 8'h00, 5'd0}}
	};

	// Valid, digit, count after each row
	keypad_pkg::key_stats_t test_expected [NUM_TESTS] = '{
		'{1'b1, 4'd5, 4'd1}, '{1'b1, 4'd5, 4'd1}, '{1'b1, 4'd3, 4'd3}, '{1'b1, 4'd9, 4'd4},
		'{1'b1, 4'd7, 4'd15}, '{1'b1, 4'd7, 4'd5}, '{1'b0, 4'd0, 4'd0}, '{1'b1, 4'd6, 4'd1}
	};

	keypad_stats_top UUT (
		.CLOCK_50_I (CLOCK_50_I),
		.resetn     (resetn),
		.ps2_clock  (ps2_clock),
		.ps2_data   (ps2_data),
		.key_stats  (key_stats),
		.frame_error(frame_error)
	);

	`include "ps2_device_model.svh"

	initial begin
		CLOCK_50_I = 1'b0;
		forever #4 CLOCK_50_I = ~CLOCK_50_I;
	end

	always @(posedge CLOCK_50_I) begin
		if (frame_error) error_seen <= 1'b1;  // Catches the one-cycle pulse
	end

	task automatic check_stats(input string name, input keypad_pkg::key_stats_t expected,
		input keypad_pkg::key_stats_t actual);
		if (actual !== expected) begin
			$display("FAIL %s expected valid=%0b digit=%0d count=%0d actual valid=%0b digit=%0d count=%0d",
				name, expected.valid, expected.digit, expected.count,
				actual.valid, actual.digit, actual.count);
			$display("Simulation failed");
			$fatal(1, "Stopped at first mismatch");
		end
	endtask

	task automatic check_error(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("FAIL %s expected frame_error seen=%0b actual=%0b", name, expected, actual);
			$display("Simulation failed");
			$fatal(1, "Stopped at first mismatch");
		end
	endtask

	task automatic wait_for_stats(input string name, input keypad_pkg::key_stats_t expected);
		int cycles;
		cycles = 0;
		while ((key_stats !== expected) && (cycles < TIMEOUT)) begin
			@(negedge CLOCK_50_I);
			cycles++;
		end
		if (key_stats !== expected) begin
			$display("Timeout waiting for the expected key_stats in test %s", name);
		end
		check_stats(name, expected, key_stats);
	endtask

	task automatic wait_for_frame_error(input string name);
		int cycles;
		cycles = 0;
		while (!error_seen && (cycles < TIMEOUT)) begin
			@(negedge CLOCK_50_I);
			cycles++;
		end
		if (!error_seen) begin
			$display("Timeout waiting for a frame_error pulse in test %s", name);
			$display("Simulation failed");
			$fatal(1, "Timeout");
		end
	endtask

	// Reference model of the history
	task automatic push_model_code(input keypad_pkg::scan_code_t code);
		keypad_pkg::digit_t digit;
		digit = 4'd15;  // Any key outside the digit row
		for (int d = 0; d < 10; d++) begin
			if (digit_codes[d] == code) digit = keypad_pkg::digit_t'(d);
		end
		for (int i = keypad_pkg::HISTORY_DEPTH - 1; i > 0; i--) begin
			model_history[i] = model_history[i-1];
		end
		model_history[0] = digit;
	endtask

	function automatic keypad_pkg::key_stats_t compute_expected_stats();
		int hits [10];
		keypad_pkg::key_stats_t result;
		result = '0;
		for (int d = 0; d < 10; d++) begin
			hits[d] = 0;
			for (int i = 0; i < keypad_pkg::HISTORY_DEPTH; i++) begin
				if (model_history[i] == d) hits[d]++;
			end
		end
		for (int d = 9; d >= 0; d--) begin  // Higher digit wins a tie
			if (hits[d] > result.count) begin
				result.digit = keypad_pkg::digit_t'(d);
				result.count = keypad_pkg::digit_count_t'(hits[d]);
			end
		end
		result.valid = (result.count != 0);
		return result;
	endfunction

	task automatic apply_event(input key_event_t ev);
		case (ev.kind)
			EV_PRESS: begin
				send_byte(ev.code);
				push_model_code(ev.code);
			end
			EV_PRESS_RELEASE: begin
				send_byte(ev.code);
				send_byte(8'hF0);  // Break prefix then released key
				send_byte(ev.code);
				push_model_code(ev.code);
			end
			EV_EXTENDED: begin
				send_byte(8'hE0);
				send_byte(ev.code);
				push_model_code(ev.code);
			end
			EV_BAD_PARITY: send_byte_bad_parity(ev.code);
			default: ;
		endcase
	endtask

	initial begin
		keypad_pkg::key_stats_t expected;
		logic expect_error;
		int pad_cycles;
		resetn     = 1'b0;
		ps2_clock  = 1'b1;
		ps2_data   = 1'b1;
		error_seen = 1'b0;
		for (int i = 0; i < keypad_pkg::HISTORY_DEPTH; i++) model_history[i] = 4'd15;
		repeat (3) @(negedge CLOCK_50_I);
		resetn = 1'b1;
		repeat (10) @(negedge CLOCK_50_I);
		check_stats("reset", '0, key_stats);
		check_error("reset", 1'b0, error_seen);

		for (int t = 0; t < NUM_TESTS; t++) begin
			error_seen   = 1'b0;
			expect_error = 1'b0;
			for (int e = 0; e < MAX_EVENTS; e++) begin
				if (test_events[t][e].kind == EV_BAD_PARITY) expect_error = 1'b1;
				for (int r = 0; r < test_events[t][e].repeats; r++) begin
					apply_event(test_events[t][e]);
					pad_cycles = $random(seed) & 31;  // Random idle gap between events
					repeat (pad_cycles) @(negedge CLOCK_50_I);
				end
			end
			expected = compute_expected_stats();
			if (expected !== test_expected[t]) begin
				$display("Reference model disagrees with the table entry of test %s", test_names[t]);
				$display("Simulation failed");
				$fatal(1, "Table inconsistent");
			end
			wait_for_stats(test_names[t], expected);
			if (expect_error) wait_for_frame_error(test_names[t]);
			check_error(test_names[t], expect_error, error_seen);
		end

		$display("Simulation passed");
		$finish;
	end

endmodule

// ==== rtl/keypad_stats_top.sv ====
// Keypad statistics top level
// PS/2 receiver, make code filter, key history and digit tally in a chain

`timescale 1ns/1ps

module keypad_stats_top (
	input  logic                   CLOCK_50_I,
	input  logic                   resetn,
	input  logic                   ps2_clock,
	input  logic                   ps2_data,
	output keypad_pkg::key_stats_t key_stats,
	output logic                   frame_error
);

	keypad_pkg::scan_code_t rx_code;
	logic                   rx_valid;
	keypad_pkg::scan_code_t make_code;
	logic                   make_valid;
	keypad_pkg::digit_t     history_digits [keypad_pkg::HISTORY_DEPTH];

	ps2_frame_receiver receiver_unit (
		.CLOCK_50_I (CLOCK_50_I),
		.resetn     (resetn),
		.ps2_clock  (ps2_clock),
		.ps2_data   (ps2_data),
		.rx_code    (rx_code),
		.rx_valid   (rx_valid),
		.frame_error(frame_error)
	);

	ps2_make_filter filter_unit (
		.CLOCK_50_I(CLOCK_50_I),
		.resetn    (resetn),
		.rx_code   (rx_code),
		.rx_valid  (rx_valid),
		.make_code (make_code),
		.make_valid(make_valid)
	);

	key_history history_unit (
		.CLOCK_50_I    (CLOCK_50_I),
		.resetn        (resetn),
		.make_code     (make_code),
		.make_valid    (make_valid),
		.history_digits(history_digits)
	);

	digit_tally tally_unit (
		.CLOCK_50_I    (CLOCK_50_I),
		.resetn        (resetn),
		.history_digits(history_digits),
		.key_stats     (key_stats)
	);

endmodule

// ==== rtl/digit_tally.sv ====
// Digit tally
// Counts every digit across the key history and registers the most frequent
// one with its count. Ties go to the higher digit.

`timescale 1ns/1ps

module digit_tally (
	input  logic                   CLOCK_50_I,
	input  logic                   resetn,
	input  keypad_pkg::digit_t     history_digits [keypad_pkg::HISTORY_DEPTH],
	output keypad_pkg::key_stats_t key_stats
);

	keypad_pkg::digit_count_t digit_counts [keypad_pkg::NUM_DIGITS];
	keypad_pkg::digit_t       best_digit;
	keypad_pkg::digit_count_t best_count;

	// Hits per digit, non-digit entries match nothing
	always_comb begin
		for (int d = 0; d < keypad_pkg::NUM_DIGITS; d++) begin
			digit_counts[d] = '0;
			for (int i = 0; i < keypad_pkg::HISTORY_DEPTH; i++) begin
				if (history_digits[i] == keypad_pkg::digit_t'(d)) begin
					digit_counts[d] = digit_counts[d] + keypad_pkg::digit_count_t'(1);
				end
			end
		end
	end

	// Scan upward so an equal count moves the pick to the higher digit
	always_comb begin
		best_digit = '0;
		best_count = digit_counts[0];
		for (int d = 1; d < keypad_pkg::NUM_DIGITS; d++) begin
			if ((digit_counts[d] != '0) && (digit_counts[d] >= best_count)) begin
				best_digit = keypad_pkg::digit_t'(d);
				best_count = digit_counts[d];
			end
		end
	end

	always_ff @(posedge CLOCK_50_I or negedge resetn) begin
		if (!resetn) begin
			key_stats <= '0;
		end else begin
			key_stats.valid <= (best_count != '0);  // No digit in history
			key_stats.digit <= best_digit;
			key_stats.count <= best_count;
		end
	end

endmodule

// ==== rtl/key_history.sv ====
// Key history
// Decodes each make code to a digit and keeps the last 15 in a shift register,
// entry 0 being the newest

`timescale 1ns/1ps

module key_history (
	input  logic                   CLOCK_50_I,
	input  logic                   resetn,
	input  keypad_pkg::scan_code_t make_code,
	input  logic                   make_valid,
	output keypad_pkg::digit_t     history_digits [keypad_pkg::HISTORY_DEPTH]
);

	keypad_pkg::digit_t new_digit;

	function automatic keypad_pkg::digit_t decode_digit(input keypad_pkg::scan_code_t code);
		keypad_pkg::digit_t result;
		case (code)
			keypad_pkg::SCAN_DIGIT_0: result = 4'd0;
			keypad_pkg::SCAN_DIGIT_1: result = 4'd1;
			keypad_pkg::SCAN_DIGIT_2: result = 4'd2;
			keypad_pkg::SCAN_DIGIT_3: result = 4'd3;
			keypad_pkg::SCAN_DIGIT_4: result = 4'd4;
			keypad_pkg::SCAN_DIGIT_5: result = 4'd5;
			keypad_pkg::SCAN_DIGIT_6: result = 4'd6;
			keypad_pkg::SCAN_DIGIT_7: result = 4'd7;
			keypad_pkg::SCAN_DIGIT_8: result = 4'd8;
			keypad_pkg::SCAN_DIGIT_9: result = 4'd9;
			default:                  result = keypad_pkg::NO_DIGIT;  // Still takes a slot
		endcase
		return result;
	endfunction

	assign new_digit = decode_digit(make_code);

	always_ff @(posedge CLOCK_50_I or negedge resetn) begin
		if (!resetn) begin
			for (int i = 0; i < keypad_pkg::HISTORY_DEPTH; i++) begin
				history_digits[i] <= keypad_pkg::NO_DIGIT;
			end
		end else if (make_valid) begin
			history_digits[0] <= new_digit;
			for (int i = 1; i < keypad_pkg::HISTORY_DEPTH; i++) begin
				history_digits[i] <= history_digits[i-1];  // Oldest entry drops off the end
			end
		end
	end

endmodule

// ==== ps2_rx/ps2_make_filter.sv ====
// PS/2 make code filter
// Drops extended prefixes and whole break sequences so only make codes pass on

`timescale 1ns/1ps

module ps2_make_filter (
	input  logic                   CLOCK_50_I,
	input  logic                   resetn,
	input  keypad_pkg::scan_code_t rx_code,
	input  logic                   rx_valid,
	output keypad_pkg::scan_code_t make_code,
	output logic                   make_valid
);

	typedef enum logic {
		FLT_IDLE,
		FLT_AFTER_BREAK
	} filter_state_t;

	filter_state_t filter_state;
	logic          is_make;

	// A plain byte seen in idle is a make code
	assign is_make = rx_valid
		&& (filter_state == FLT_IDLE)
		&& (rx_code != keypad_pkg::SCAN_EXTENDED)
		&& (rx_code != keypad_pkg::SCAN_BREAK);

	always_ff @(posedge CLOCK_50_I or negedge resetn) begin
		if (!resetn) begin
			filter_state <= FLT_IDLE;
			make_valid   <= 1'b0;
		end else begin
			make_valid <= is_make;
			if (rx_valid) begin
				case (filter_state)
					FLT_IDLE: begin
						if (rx_code == keypad_pkg::SCAN_BREAK) begin
							filter_state <= FLT_AFTER_BREAK;  // Next byte is the released key
						end
					end
					FLT_AFTER_BREAK: begin
						filter_state <= FLT_IDLE;  // Released key swallowed
					end
					default: begin
						filter_state <= FLT_IDLE;
					end
				endcase
			end
		end
	end

	always_ff @(posedge CLOCK_50_I) begin
		if (is_make) begin
			make_code <= rx_code;
		end
	end

endmodule

// ==== ps2_rx/ps2_frame_receiver.sv ====
// PS/2 frame receiver
// Synchronizes the keyboard clock and data lines, shifts in 11-bit frames
// on falling clock edges and checks start, odd parity and stop bits.

`timescale 1ns/1ps

module ps2_frame_receiver (
	input  logic                   CLOCK_50_I,
	input  logic                   resetn,
	input  logic                   ps2_clock,
	input  logic                   ps2_data,
	output keypad_pkg::scan_code_t rx_code,
	output logic                   rx_valid,
	output logic                   frame_error
);

	typedef enum logic {
		RX_IDLE,
		RX_RECEIVING
	} rx_state_t;

	rx_state_t rx_state;

	logic [1:0] clock_sync;  // Two-flop synchronizers
	logic [1:0] data_sync;
	logic       clock_prev;
	logic       clock_fall;

	keypad_pkg::ps2_bit_count_t bit_count;
	logic [keypad_pkg::PS2_FRAME_BITS-1:0] frame_shift;
	logic [keypad_pkg::PS2_FRAME_BITS-1:0] frame_next;
	logic last_bit;
	logic frame_ok;

	always_ff @(posedge CLOCK_50_I or negedge resetn) begin
		if (!resetn) begin
			clock_sync <= 2'b11;  // Bus idles high
			data_sync  <= 2'b11;
			clock_prev <= 1'b1;
		end else begin
			clock_sync <= {clock_sync[0], ps2_clock};
			data_sync  <= {data_sync[0], ps2_data};
			clock_prev <= clock_sync[1];
		end
	end

	assign clock_fall = clock_prev & ~clock_sync[1];

	// LSB arrives first, so new bits enter at the top
	assign frame_next = {data_sync[1], frame_shift[keypad_pkg::PS2_FRAME_BITS-1:1]};

	assign last_bit = (bit_count ==
		keypad_pkg::ps2_bit_count_t'(keypad_pkg::PS2_FRAME_BITS - 1));

	// Start low, stop high, odd parity over data and parity bit
	assign frame_ok = ~frame_next[0]
		& frame_next[keypad_pkg::PS2_FRAME_BITS-1]
		& (^frame_next[keypad_pkg::PS2_FRAME_BITS-2:1]);

	always_ff @(posedge CLOCK_50_I or negedge resetn) begin
		if (!resetn) begin
			rx_state    <= RX_IDLE;
			bit_count   <= '0;
			rx_valid    <= 1'b0;
			frame_error <= 1'b0;
		end else begin
			rx_valid    <= 1'b0;  // Single-cycle pulses
			frame_error <= 1'b0;
			if (clock_fall) begin
				case (rx_state)
					RX_IDLE: begin
						bit_count <= keypad_pkg::ps2_bit_count_t'(1);  // Start bit taken
						rx_state  <= RX_RECEIVING;
					end
					RX_RECEIVING: begin
						if (last_bit) begin
							bit_count   <= '0;
							rx_state    <= RX_IDLE;
							rx_valid    <= frame_ok;
							frame_error <= ~frame_ok;
						end else begin
							bit_count <= bit_count + keypad_pkg::ps2_bit_count_t'(1);
						end
					end
					default: begin
						rx_state <= RX_IDLE;
					end
				endcase
			end
		end
	end

	// Frame bits and received byte
	always_ff @(posedge CLOCK_50_I) begin
		if (clock_fall) begin
			frame_shift <= frame_next;
		end
		if (clock_fall && last_bit) begin
			rx_code <= frame_next[8:1];  // Data byte between start and parity
		end
	end

endmodule

// ==== common/keypad_pkg.sv ====
// Keypad statistics shared definitions
// Scan code constants, frame format and the result record that leaves the top level

package keypad_pkg;

	localparam int HISTORY_DEPTH  = 15;  // Make codes kept in the history
	localparam int NUM_DIGITS     = 10;
	localparam int PS2_FRAME_BITS = 11;  // Start, 8 data, parity, stop
	localparam int PS2_COUNT_W    = $clog2(PS2_FRAME_BITS);

	typedef logic [7:0] scan_code_t;
	typedef logic [3:0] digit_t;
	typedef logic [3:0] digit_count_t;  // 0 to 15 hits in the history
	typedef logic [PS2_COUNT_W-1:0] ps2_bit_count_t;

	localparam digit_t NO_DIGIT = 4'd15;  // Key outside 0 to 9

	localparam scan_code_t SCAN_BREAK    = 8'hF0;
	localparam scan_code_t SCAN_EXTENDED = 8'hE0;

	// Set 2 make codes of the top row digits
	localparam scan_code_t SCAN_DIGIT_0 = 8'h45;
	localparam scan_code_t SCAN_DIGIT_1 = 8'h16;
	localparam scan_code_t SCAN_DIGIT_2 = 8'h1E;
	localparam scan_code_t SCAN_DIGIT_3 = 8'h26;
	localparam scan_code_t SCAN_DIGIT_4 = 8'h25;
	localparam scan_code_t SCAN_DIGIT_5 = 8'h2E;
	localparam scan_code_t SCAN_DIGIT_6 = 8'h36;
	localparam scan_code_t SCAN_DIGIT_7 = 8'h3D;
	localparam scan_code_t SCAN_DIGIT_8 = 8'h3E;
	localparam scan_code_t SCAN_DIGIT_9 = 8'h46;

	typedef struct packed {
		logic         valid;  // Count nonzero
		digit_t       digit;  // Most frequent digit
		digit_count_t count;  // Its number of hits
	} key_stats_t;

endpackage
